/* frame_ctrl.f */
source/frame_ctrl_pkg.sv
source/status_decode.sv
source/sync_resync.sv
source/ddr_port_mux.sv
source/frame_ctrl.sv
dv/tb_clkgen.sv
dv/frame_ctrl_sva.sv
dv/frame_ctrl_tb.sv

/* dv/frame_ctrl_tb.sv */
//##########################################################################
// Testbench top with stimulus phases, LCG and timeouts
//##########################################################################
`timescale 1ns/10ps

module frame_ctrl_tb;

    logic        clk_sys;
    logic        rst_n;
    logic [63:0] status;
    logic [6:0]  core_mod;
    logic        rotate, direct_video;
    logic [3:0]  hoffset, voffset;
    logic        hsize_enable, shadowmask_2x, shadowmask_rot, db15_en, fb_flip;
    logic [3:0]  hsize_scale;
    logic [2:0]  shadowmask;
    logic [15:0] status_menumask;
    logic        hs, vs, pxl_cen, hs_out, vs_out;
    logic        downloading, ld_rd, ld_busy;
    logic [7:0]  ld_burstcnt, rot_burstcnt, rot_be, ddr_burstcnt, ddr_be;
    logic [28:0] ld_addr, rot_addr, ddr_addr;
    logic        rot_rd, rot_we, rot_busy;
    logic        ddr_busy, ddr_dout_ready, ddr_rd, ddr_we;
    logic [31:0] lcg_state;

    tb_clkgen u_clkgen (.clk_sys(clk_sys), .rst_n(rst_n));

    frame_ctrl uut (.*);

    function automatic logic [31:0] lcg_next(inout logic [31:0] st);
        st = st * 32'd1103515245 + 32'd12345;
        return st;
    endfunction

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Any assertion failure ends the run
    always @(negedge clk_sys) begin
        if (uut.u_sva.err_count != 0)
            stop_failed("An assertion on the DUT failed");
    end

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk_sys);
            n++;
            if (n > 20)
                stop_failed("Timeout waiting for reset release");
        end
    endtask

    // Loader owns the port exactly when rot_busy is high and ddr_busy is low
    task automatic wait_owner(input logic loader);
        int n;
        n = 0;
        while (rot_busy !== loader) begin
            @(negedge clk_sys);
            n++;
            if (n > 50)
                stop_failed("Timeout waiting for DDR ownership to change");
        end
    endtask

    task automatic wait_ld_free();
        int n;
        n = 0;
        while (ld_busy !== 1'b0) begin
            @(negedge clk_sys);
            n++;
            if (n > 50)
                stop_failed("Timeout waiting for loader busy to clear");
        end
    endtask

    initial begin
        int cyc;
        lcg_state      = 32'd36;
        status         = '0;
        core_mod       = '0;
        rotate         = 0;
        direct_video   = 0;
        hs             = 0;
        vs             = 0;
        pxl_cen        = 0;
        downloading    = 0;
        ld_burstcnt    = '0;
        ld_addr        = '0;
        ld_rd          = 0;
        rot_burstcnt   = '0;
        rot_addr       = '0;
        rot_rd         = 0;
        rot_we         = 0;
        rot_be         = '0;
        ddr_busy       = 0;
        ddr_dout_ready = 0;
        wait_reset_done();

        // Random status decode
        repeat (40) begin
            @(negedge clk_sys);
            status       = {lcg_next(lcg_state), lcg_next(lcg_state)};
            core_mod     = 7'(lcg_next(lcg_state) >> 9);
            rotate       = 1'(lcg_next(lcg_state) >> 16);
            direct_video = 1'(lcg_next(lcg_state) >> 17);
            pxl_cen      = 1'(lcg_next(lcg_state) >> 18);
            hs           = 1'(lcg_next(lcg_state) >> 19);
            vs           = 1'(lcg_next(lcg_state) >> 20);
        end

        // Sync re-timing with hoffset 3 and voffset 1
        @(negedge clk_sys);
        status  = 64'h0000_0000_1300_0000;
        pxl_cen = 1'b1;
        for (cyc = 0; cyc < 240; cyc++) begin
            @(negedge clk_sys);
            hs = (cyc % 12) < 4;
            vs = (cyc % 96) < 24;
        end

        // Downloading falls while a loader burst is pending
        downloading = 1'b1;
        wait_owner(1'b1);
        wait_ld_free();
        ld_burstcnt = 8'd4;
        ld_addr     = 29'(lcg_next(lcg_state));
        ld_rd       = 1'b1;
        @(negedge clk_sys);
        ld_rd       = 1'b0;
        downloading = 1'b0;
        repeat (4) begin
            repeat (lcg_next(lcg_state) % 3) @(negedge clk_sys);
            ddr_dout_ready = 1'b1;
            @(negedge clk_sys);
            ddr_dout_ready = 1'b0;
        end
        wait_owner(1'b0);

        // Rotator writes
        repeat (20) begin
            @(negedge clk_sys);
            ddr_busy     = (lcg_next(lcg_state) % 4) == 0;
            rot_we       = 1'(lcg_next(lcg_state) >> 21) & ~ddr_busy;
            rot_be       = 8'(lcg_next(lcg_state) >> 8);
            rot_addr     = 29'(lcg_next(lcg_state));
            rot_burstcnt = 8'(lcg_next(lcg_state) >> 12);
        end
        @(negedge clk_sys);
        rot_we   = 1'b0;
        ddr_busy = 1'b0;
        repeat (4) @(negedge clk_sys);

        if (uut.u_sva.err_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_failed("Assertion errors were counted");
        end
    end

    // Global guard against a stuck run
    initial begin
        #1ms;
        stop_failed("Timeout on the whole simulation");
    end

endmodule

/* dv/frame_ctrl_sva.sv */
//##########################################################################
// Bound assertions for status decode, sync re-timing and DDR port sharing
//##########################################################################
`timescale 1ns/10ps

module frame_ctrl_sva #(
    parameter int DDR_AW = 29
) (
    input logic              clk_sys,
    input logic              rst_n,
    input logic [63:0]       status,
    input logic [6:0]        core_mod,
    input logic              rotate,
    input logic              direct_video,
    input logic [3:0]        hoffset,
    input logic [3:0]        voffset,
    input logic              hsize_enable,
    input logic [3:0]        hsize_scale,
    input logic [2:0]        shadowmask,
    input logic              shadowmask_2x,
    input logic              shadowmask_rot,
    input logic              db15_en,
    input logic              fb_flip,
    input logic [15:0]       status_menumask,
    input logic              hs,
    input logic              pxl_cen,
    input logic              hs_out,
    input logic              vs_out,
    input logic              downloading,
    input logic [7:0]        ld_burstcnt,
    input logic [DDR_AW-1:0] ld_addr,
    input logic              ld_rd,
    input logic              ld_busy,
    input logic [7:0]        rot_burstcnt,
    input logic [DDR_AW-1:0] rot_addr,
    input logic              rot_rd,
    input logic              rot_we,
    input logic [7:0]        rot_be,
    input logic              rot_busy,
    input logic              ddr_busy,
    input logic              ddr_dout_ready,
    input logic [7:0]        ddr_burstcnt,
    input logic [DDR_AW-1:0] ddr_addr,
    input logic              ddr_rd,
    input logic              ddr_we,
    input logic [7:0]        ddr_be
);

    import frame_ctrl_pkg::*;

    int         err_count = 0;  // Read by the testbench top
    logic [3:0] sync_run;       // Consecutive pixel ticks since reset
    logic       hs_seen;        // hs at the last pixel tick
    logic       line_tick;
    logic       own_ref;        // Expected owner, 1 for the loader
    logic [7:0] pend_ref;
    logic       ld_take;
    logic       rot_take;

    assign line_tick = pxl_cen & hs & ~hs_seen;
    assign ld_take   = own_ref & ld_rd & ~ddr_busy;
    assign rot_take  = ~own_ref & rot_rd & ~ddr_busy;

    // Menu mask for the default layout
    function automatic logic [15:0] menu_expect(logic [63:0] st, logic [6:0] cm, logic dv);
        logic [15:0] m;
        m    = '0;
        m[0] = dv;
        m[1] = ~cm[0];
        m[2] = ~st[19];
        m[3] = st[34:32] == 3'd0;
        m[4] = 1'b1;
        return m;
    endfunction

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sync_run <= '0;
            hs_seen  <= 1'b0;
        end else if (pxl_cen) begin
            sync_run <= (sync_run == 4'hf) ? sync_run : sync_run + 1'b1;
            hs_seen  <= hs;
        end else begin
            sync_run <= '0;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            own_ref  <= 1'b0;
            pend_ref <= '0;
        end else begin
            if (pend_ref == '0 && !ddr_busy && !ld_take && !rot_take)
                own_ref <= downloading;
            if (ld_take)
                pend_ref <= ld_burstcnt;
            else if (rot_take)
                pend_ref <= rot_burstcnt;
            else if (ddr_dout_ready && pend_ref != '0)
                pend_ref <= pend_ref - 1'b1;
        end
    end

    a_reset: assert property (@(posedge clk_sys) !rst_n |->
        hoffset == 0 && voffset == 0 && !hsize_enable && hsize_scale == 0 &&
        shadowmask == 0 && !shadowmask_2x && !shadowmask_rot && !db15_en &&
        !fb_flip && status_menumask == 0 && !hs_out && !vs_out &&
        !ddr_rd && !ddr_we && ld_busy)
    else begin
        err_count++;
        $error("Error reset state status_menumask %h hs_out %h vs_out %h ld_busy %h",
               status_menumask, hs_out, vs_out, ld_busy);
    end

    a_offsets: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $past(rst_n) |-> {voffset, hoffset} == $past(status[31:24]))
    else begin
        err_count++;
        $error("Error voffset/hoffset %h expected %h", {voffset, hoffset}, $past(status[31:24]));
    end

    a_hsize: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $past(rst_n) |-> {hsize_scale, hsize_enable} == $past(status[23:19]))
    else begin
        err_count++;
        $error("Error hsize_scale/hsize_enable %h expected %h",
               {hsize_scale, hsize_enable}, $past(status[23:19]));
    end

    a_mask: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $past(rst_n) |-> {db15_en, shadowmask_2x, shadowmask} == $past({status[37], status[35:32]})
        && shadowmask_rot == $past(status[36] ^ (core_mod[0] & rotate))
        && fb_flip == $past(status[39:38] == 2'd2))
    else begin
        err_count++;
        $error("Error shadowmask %h shadowmask_rot %h fb_flip %h db15_en %h",
               shadowmask, shadowmask_rot, fb_flip, db15_en);
    end

    a_menu: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $past(rst_n) |-> status_menumask == menu_expect($past(status), $past(core_mod),
                                                        $past(direct_video)))
    else begin
        err_count++;
        $error("Error status_menumask %h expected %h", status_menumask,
               menu_expect($past(status), $past(core_mod), $past(direct_video)));
    end

    a_hsync: assert property (@(posedge clk_sys) disable iff (!rst_n)
        sync_run >= 5 && $past(hoffset) == 3 |-> hs_out == $past(hs, 4))
    else begin
        err_count++;
        $error("Error hs_out %h expected %h", hs_out, $past(hs, 4));
    end

    a_vsync: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $changed(vs_out) |-> $past(line_tick))
    else begin
        err_count++;
        $error("vs_out changed without a line tick in the previous cycle");
    end

    a_loader_own: assert property (@(posedge clk_sys) disable iff (!rst_n)
        own_ref |-> ddr_rd == ld_rd && !ddr_we && rot_busy && ld_busy == ddr_busy)
    else begin
        err_count++;
        $error("Error loader owner ddr_rd %h ddr_we %h rot_busy %h ld_busy %h",
               ddr_rd, ddr_we, rot_busy, ld_busy);
    end

    a_loader_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
        own_ref |-> ddr_be == '1 && ddr_burstcnt == ld_burstcnt && ddr_addr == ld_addr)
    else begin
        err_count++;
        $error("Error loader owner ddr_be %h ddr_burstcnt %h ddr_addr %h",
               ddr_be, ddr_burstcnt, ddr_addr);
    end

    a_rot_own: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !own_ref |-> ddr_we == rot_we && ddr_be == rot_be && ld_busy && rot_busy == ddr_busy)
    else begin
        err_count++;
        $error("Error rotator owner ddr_we %h ddr_be %h ld_busy %h rot_busy %h",
               ddr_we, ddr_be, ld_busy, rot_busy);
    end

    a_rot_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !own_ref |-> ddr_rd == rot_rd && ddr_burstcnt == rot_burstcnt && ddr_addr == rot_addr)
    else begin
        err_count++;
        $error("Error rotator owner ddr_rd %h ddr_burstcnt %h ddr_addr %h",
               ddr_rd, ddr_burstcnt, ddr_addr);
    end

    // Loader keeps the port until its burst has drained
    a_burst_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
        own_ref && pend_ref != 0 |=> rot_busy)
    else begin
        err_count++;
        $error("Loader lost the DDR port while read beats were pending");
    end

endmodule

bind frame_ctrl frame_ctrl_sva #(.DDR_AW(DDR_AW)) u_sva (.*);

/* dv/tb_clkgen.sv */
//##########################################################################
// Testbench clock and reset generator
//##########################################################################
`timescale 1ns/10ps

module tb_clkgen #(
    parameter realtime PERIOD     = 100ns,
    parameter int      RST_CYCLES = 3
) (
    output logic clk_sys,
    output logic rst_n
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_n = 1'b1;  // Release away from the active edge
    end

endmodule

/* source/frame_ctrl.sv */
//##########################################################################
// Frame control top level with status decode, sync re-timing and DDR mux
//##########################################################################
`timescale 1ns/10ps

module frame_ctrl #(
    parameter int DDR_AW      = 29,
    parameter bit ROTATE_MENU = 1'b0
) (
    input  logic                                  clk_sys,
    input  logic                                  rst_n,
    // OSD configuration
    input  logic [frame_ctrl_pkg::STATUS_W-1:0]   status,
    input  logic [frame_ctrl_pkg::CORE_MOD_W-1:0] core_mod,
    input  logic                                  rotate,
    input  logic                                  direct_video,
    output logic [frame_ctrl_pkg::OFFSET_W-1:0]   hoffset,
    output logic [frame_ctrl_pkg::OFFSET_W-1:0]   voffset,
    output logic                                  hsize_enable,
    output logic [3:0]                            hsize_scale,
    output logic [2:0]                            shadowmask,
    output logic                                  shadowmask_2x,
    output logic                                  shadowmask_rot,
    output logic                                  db15_en,
    output logic                                  fb_flip,
    output logic [frame_ctrl_pkg::MENUMASK_W-1:0] status_menumask,
    // Game video sync
    input  logic                                  hs,
    input  logic                                  vs,
    input  logic                                  pxl_cen,
    output logic                                  hs_out,
    output logic                                  vs_out,
    // Fast loader
    input  logic                                  downloading,
    input  logic [frame_ctrl_pkg::DDR_BCW-1:0]    ld_burstcnt,
    input  logic [DDR_AW-1:0]                     ld_addr,
    input  logic                                  ld_rd,
    output logic                                  ld_busy,
    // Screen rotation
    input  logic [frame_ctrl_pkg::DDR_BCW-1:0]    rot_burstcnt,
    input  logic [DDR_AW-1:0]                     rot_addr,
    input  logic                                  rot_rd,
    input  logic                                  rot_we,
    input  logic [frame_ctrl_pkg::DDR_BEW-1:0]    rot_be,
    output logic                                  rot_busy,
    // DDR port
    input  logic                                  ddr_busy,
    input  logic                                  ddr_dout_ready,
    output logic [frame_ctrl_pkg::DDR_BCW-1:0]    ddr_burstcnt,
    output logic [DDR_AW-1:0]                     ddr_addr,
    output logic                                  ddr_rd,
    output logic                                  ddr_we,
    output logic [frame_ctrl_pkg::DDR_BEW-1:0]    ddr_be
);

    status_decode #(
        .ROTATE_MENU     ( ROTATE_MENU     )
    ) u_decode (
        .clk_sys         ( clk_sys         ),
        .rst_n           ( rst_n           ),
        .status          ( status          ),
        .core_mod        ( core_mod        ),
        .rotate          ( rotate          ),
        .direct_video    ( direct_video    ),
        .hoffset         ( hoffset         ),
        .voffset         ( voffset         ),
        .hsize_enable    ( hsize_enable    ),
        .hsize_scale     ( hsize_scale     ),
        .shadowmask      ( shadowmask      ),
        .shadowmask_2x   ( shadowmask_2x   ),
        .shadowmask_rot  ( shadowmask_rot  ),
        .db15_en         ( db15_en         ),
        .fb_flip         ( fb_flip         ),
        .status_menumask ( status_menumask )
    );

    // Offsets come from the decoder registers
    sync_resync u_resync (
        .clk_sys         ( clk_sys         ),
        .rst_n           ( rst_n           ),
        .pxl_cen         ( pxl_cen         ),
        .hs              ( hs              ),
        .vs              ( vs              ),
        .hoffset         ( hoffset         ),
        .voffset         ( voffset         ),
        .hs_out          ( hs_out          ),
        .vs_out          ( vs_out          )
    );

    ddr_port_mux #(
        .DDR_AW          ( DDR_AW          )
    ) u_ddrmux (
        .clk_sys         ( clk_sys         ),
        .rst_n           ( rst_n           ),
        .downloading     ( downloading     ),
        .ld_burstcnt     ( ld_burstcnt     ),
        .ld_addr         ( ld_addr         ),
        .ld_rd           ( ld_rd           ),
        .ld_busy         ( ld_busy         ),
        .rot_burstcnt    ( rot_burstcnt    ),
        .rot_addr        ( rot_addr        ),
        .rot_rd          ( rot_rd          ),
        .rot_we          ( rot_we          ),
        .rot_be          ( rot_be          ),
        .rot_busy        ( rot_busy        ),
        .ddr_busy        ( ddr_busy        ),
        .ddr_dout_ready  ( ddr_dout_ready  ),
        .ddr_burstcnt    ( ddr_burstcnt    ),
        .ddr_addr        ( ddr_addr        ),
        .ddr_rd          ( ddr_rd          ),
        .ddr_we          ( ddr_we          ),
        .ddr_be          ( ddr_be          )
    );

endmodule

/* source/ddr_port_mux.sv */
//##########################################################################
// Shared DDR port between fast-load reader and rotation writer
//##########################################################################
`timescale 1ns/10ps

module ddr_port_mux #(
    parameter int DDR_AW = 29
) (
    input  logic                               clk_sys,
    input  logic                               rst_n,
    input  logic                               downloading,
    // Fast loader, read only
    input  logic [frame_ctrl_pkg::DDR_BCW-1:0] ld_burstcnt,
    input  logic [DDR_AW-1:0]                  ld_addr,
    input  logic                               ld_rd,
    output logic                               ld_busy,
    // Screen rotation
    input  logic [frame_ctrl_pkg::DDR_BCW-1:0] rot_burstcnt,
    input  logic [DDR_AW-1:0]                  rot_addr,
    input  logic                               rot_rd,
    input  logic                               rot_we,
    input  logic [frame_ctrl_pkg::DDR_BEW-1:0] rot_be,
    output logic                               rot_busy,
    // DDR side
    input  logic                               ddr_busy,
    input  logic                               ddr_dout_ready,
    output logic [frame_ctrl_pkg::DDR_BCW-1:0] ddr_burstcnt,
    output logic [DDR_AW-1:0]                  ddr_addr,
    output logic                               ddr_rd,
    output logic                               ddr_we,
    output logic [frame_ctrl_pkg::DDR_BEW-1:0] ddr_be
);

    import frame_ctrl_pkg::*;

    logic               ld_own;   // 1 while the loader holds the port
    logic [DDR_BCW-1:0] pending;  // Read beats still to come back
    logic               ld_acc;
    logic               rot_acc;
    logic               idle;

    assign ld_acc  = ld_own & ld_rd & ~ddr_busy;
    assign rot_acc = ~ld_own & rot_rd & ~ddr_busy;

    // A read accepted this cycle counts as pending
    assign idle = (pending == '0) & ~ddr_busy & ~ld_acc & ~rot_acc;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            ld_own <= 1'b0;
        end else if (idle) begin
            ld_own <= downloading;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (ld_acc) begin
            pending <= ld_burstcnt;
        end else if (rot_acc) begin
            pending <= rot_burstcnt;
        end else if (ddr_dout_ready && pending != '0) begin
            pending <= pending - 1'b1;
        end
    end

    // Request steering from the current owner
    always_comb begin
        if (ld_own) begin
            ddr_burstcnt = ld_burstcnt;
            ddr_addr     = ld_addr;
            ddr_rd       = ld_rd;
            ddr_we       = 1'b0;
            ddr_be       = '1;
        end else begin
            ddr_burstcnt = rot_burstcnt;
            ddr_addr     = rot_addr;
            ddr_rd       = rot_rd;
            ddr_we       = rot_we;
            ddr_be       = rot_be;
        end
    end

    assign ld_busy  = ld_own ? ddr_busy : 1'b1;   // Locked out unless owner
    assign rot_busy = ld_own ? 1'b1 : ddr_busy;

endmodule

/* source/sync_resync.sv */
//##########################################################################
// Sync re-timing with pixel delay for hsync and line delay for vsync
//##########################################################################
`timescale 1ns/10ps

module sync_resync (
    input  logic                                clk_sys,
    input  logic                                rst_n,
    input  logic                                pxl_cen,
    input  logic                                hs,
    input  logic                                vs,
    input  logic [frame_ctrl_pkg::OFFSET_W-1:0] hoffset,
    input  logic [frame_ctrl_pkg::OFFSET_W-1:0] voffset,
    output logic                                hs_out,
    output logic                                vs_out
);

    import frame_ctrl_pkg::*;

    localparam int TAPS = 1 << OFFSET_W;

    // Tap 0 is the live input, so only TAPS-1 stages are stored
    logic [TAPS-2:0] hs_dly;
    logic [TAPS-2:0] vs_dly;
    logic [TAPS-1:0] hs_next;
    logic [TAPS-1:0] vs_next;
    logic            hs_last;    // hs at the previous pixel tick
    logic            line_tick;

    assign hs_next   = {hs_dly, hs};
    assign vs_next   = {vs_dly, vs};
    assign line_tick = pxl_cen & hs & ~hs_last;  // Rising hs edge

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_dly  <= '0;
            hs_last <= 1'b0;
            hs_out  <= 1'b0;
        end else if (pxl_cen) begin
            hs_dly  <= hs_next[TAPS-2:0];
            hs_last <= hs;
            hs_out  <= hs_next[hoffset];
        end
    end

    // Vertical delay counts whole lines
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            vs_dly <= '0;
            vs_out <= 1'b0;
        end else if (line_tick) begin
            vs_dly <= vs_next[TAPS-2:0];
            vs_out <= vs_next[voffset];
        end
    end

endmodule

/* source/status_decode.sv */
//##########################################################################
// Registered OSD status decode into video settings and menu-hide mask
//##########################################################################
`timescale 1ns/10ps

module status_decode #(
    parameter bit ROTATE_MENU = 1'b0
) (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic [frame_ctrl_pkg::STATUS_W-1:0]  status,
    input  logic [frame_ctrl_pkg::CORE_MOD_W-1:0] core_mod,
    input  logic                                 rotate,
    input  logic                                 direct_video,
    output logic [frame_ctrl_pkg::OFFSET_W-1:0]  hoffset,
    output logic [frame_ctrl_pkg::OFFSET_W-1:0]  voffset,
    output logic                                 hsize_enable,
    output logic [3:0]                           hsize_scale,
    output logic [2:0]                           shadowmask,
    output logic                                 shadowmask_2x,
    output logic                                 shadowmask_rot,
    output logic                                 db15_en,
    output logic                                 fb_flip,
    output logic [frame_ctrl_pkg::MENUMASK_W-1:0] status_menumask
);

    import frame_ctrl_pkg::*;

    logic [MENUMASK_W-1:0] menu_nxt;  // High hides the OSD item
    logic                  vertical;

    assign vertical = core_mod[0];

    always_comb begin
        menu_nxt    = '0;
        menu_nxt[0] = direct_video;
        menu_nxt[2] = ~status[HSIZE_EN_BIT];            // Scale entries
        menu_nxt[3] = status[SHMASK_LSB +: 3] == 3'd0;  // Mask filter entries
        if (ROTATE_MENU) begin
            menu_nxt[1] = 1'b1;
            menu_nxt[4] = ~vertical;  // Extra rotate options
        end else begin
            menu_nxt[1] = ~vertical;
            menu_nxt[4] = 1'b1;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hoffset         <= '0;
            voffset         <= '0;
            hsize_enable    <= 1'b0;
            hsize_scale     <= '0;
            shadowmask      <= '0;
            shadowmask_2x   <= 1'b0;
            shadowmask_rot  <= 1'b0;
            db15_en         <= 1'b0;
            fb_flip         <= 1'b0;
            status_menumask <= '0;
        end else begin
            hoffset         <= status[HOFF_LSB +: OFFSET_W];
            voffset         <= status[VOFF_LSB +: OFFSET_W];
            hsize_enable    <= status[HSIZE_EN_BIT];
            hsize_scale     <= status[HSIZE_LSB +: 4];
            shadowmask      <= status[SHMASK_LSB +: 3];
            shadowmask_2x   <= status[SHMASK_2X_BIT];
            // Vertical game on a rotated screen flips the mask orientation
            shadowmask_rot  <= status[SHMASK_ROT_BIT] ^ (vertical & rotate);
            db15_en         <= status[DB15_BIT];
            fb_flip         <= status[FLIP_LSB +: 2] == 2'(FLIP_MODE);
            status_menumask <= menu_nxt;
        end
    end

endmodule

/* source/frame_ctrl_pkg.sv */
//##########################################################################
// Status word field positions, video setting widths and DDR port constants
//##########################################################################

package frame_ctrl_pkg;

    // Status word
    localparam int STATUS_W       = 64;
    localparam int OFFSET_W       = 4;

    localparam int HSIZE_EN_BIT   = 19;
    localparam int HSIZE_LSB      = 20;  // 4-bit scale
    localparam int HOFF_LSB       = 24;
    localparam int VOFF_LSB       = 28;
    localparam int SHMASK_LSB     = 32;  // 3-bit mask select
    localparam int SHMASK_2X_BIT  = 35;
    localparam int SHMASK_ROT_BIT = 36;
    localparam int DB15_BIT       = 37;
    localparam int FLIP_LSB       = 38;  // 2-bit framebuffer mode

    localparam int FLIP_MODE      = 2;

    // OSD menu and core mode
    localparam int MENUMASK_W     = 16;
    localparam int CORE_MOD_W     = 7;   // Bit 0 set for vertical games

    // DDR port
    localparam int DDR_DW         = 64;
    localparam int DDR_BEW        = DDR_DW / 8;
    localparam int DDR_BCW        = 8;

endpackage
